// ==== dv/read_dp_tb.sv ====
module read_dp_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_READ_LATENCY = 16;
	localparam int MEM_T_RL         = 11;

	// Termination is released from 3 to 8 edges after the full read enable was sampled
	localparam int OCT_ON  = 3;
	localparam int OCT_OFF = 8;

	// Longest any wait loop may run in clock cycles
	localparam int WAIT_LIMIT = 64;

	logic                   pll_afi_clk;
	logic                   reset_n_afi_clk;
	read_dp_pkg::rate_vec_t afi_rdata_en_i;
	read_dp_pkg::rate_vec_t afi_rdata_en_full_i;
	read_dp_pkg::lat_cnt_t  seq_read_latency_counter_i;
	read_dp_pkg::afi_data_t ddio_phy_dq_i;
	read_dp_pkg::afi_data_t afi_rdata_o;
	read_dp_pkg::afi_data_t phy_mux_read_fifo_q_o;
	read_dp_pkg::rate_vec_t afi_rdata_valid_o;
	read_dp_pkg::dqs_vec_t  force_oct_off_o;

	// Request bit, full enable and latency as sampled at each rising edge and indexed by edge
	logic                  req_q [$];
	logic                  full_q [$];
	read_dp_pkg::lat_cnt_t lat_q [$];
	int                    edge_n = 0;

	int          valid_errors;
	int          data_errors;
	int          oct_errors;
	int unsigned seed_draw;
	int          lat_list [3] = '{1, 7, 16};

	read_dp_top #(
		.MAX_READ_LATENCY (MAX_READ_LATENCY),
		.MEM_T_RL         (MEM_T_RL)
	) uut (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.afi_rdata_o                (afi_rdata_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever
		begin
			#5 pll_afi_clk = ~pll_afi_clk;
		end
	end

	// **************************************************
	// Reference model
	// **************************************************

	// Valid after edge n repeats the request of edge n-L-1, where L is the
	// latency the DUT saw on the edge before
	function automatic read_dp_pkg::rate_vec_t expected_valid(input int n);
		int src;
		if (n < 1)
		begin
			return '0;
		end
		src = n - int'(lat_q[n-1]) - 1;
		if (src < 0)
		begin
			return '0;
		end
		return {read_dp_pkg::AFI_RATE_RATIO{req_q[src]}};
	endfunction

	// Termination is released while any full enable is 3 to 8 edges old
	function automatic read_dp_pkg::dqs_vec_t expected_oct(input int n);
		logic in_window;
		in_window = 1'b0;
		for (int j = OCT_ON; j <= OCT_OFF; j++)
		begin
			if (n - j >= 0)
			begin
				in_window = in_window | full_q[n-j];
			end
		end
		if (in_window)
		begin
			return '0;
		end
		return '1;
	endfunction

	// Lane (g, t) is at g*32 + t*8 on the capture bus and at t*16 + g*8 on the AFI,
	// while the sequencer view keeps the capture order
	function automatic void expected_data(input read_dp_pkg::afi_data_t dq,
		output read_dp_pkg::afi_data_t slot_order, output read_dp_pkg::afi_data_t group_order);
		for (int g = 0; g < read_dp_pkg::MEM_READ_DQS_WIDTH; g++)
		begin
			for (int t = 0; t < read_dp_pkg::NUM_TIMESLOTS; t++)
			begin
				slot_order[t*16 + g*8 +: 8]  = dq[g*32 + t*8 +: 8];
				group_order[g*32 + t*8 +: 8] = dq[g*32 + t*8 +: 8];
			end
		end
	endfunction

	task automatic check_valid(input string name, input read_dp_pkg::rate_vec_t exp_v,
		input read_dp_pkg::rate_vec_t act_v);
		if (act_v !== exp_v)
		begin
			valid_errors++;
			$display("mismatch at %0d ns: %s expected %b, got %b", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_data(input string name, input read_dp_pkg::afi_data_t exp_v,
		input read_dp_pkg::afi_data_t act_v);
		if (act_v !== exp_v)
		begin
			data_errors++;
			$display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_oct(input string name, input read_dp_pkg::dqs_vec_t exp_v,
		input read_dp_pkg::dqs_vec_t act_v);
		if (act_v !== exp_v)
		begin
			oct_errors++;
			$display("mismatch at %0d ns: %s expected %b, got %b", $time, name, exp_v, act_v);
		end
	endtask

	// Record what the DUT sampled, then compare once the outputs have settled
	always @(posedge pll_afi_clk)
	begin : compare_proc
		int n;
		read_dp_pkg::afi_data_t exp_slot;
		read_dp_pkg::afi_data_t exp_group;
		n = edge_n;
		edge_n++;
		// Histories hold zeros while reset is asserted
		req_q.push_back(reset_n_afi_clk & afi_rdata_en_i[0]);
		full_q.push_back(reset_n_afi_clk & afi_rdata_en_full_i[0]);
		lat_q.push_back(seq_read_latency_counter_i);
		#1;
		expected_data(ddio_phy_dq_i, exp_slot, exp_group);
		check_data("afi_rdata", exp_slot, afi_rdata_o);
		check_data("phy_mux_read_fifo_q", exp_group, phy_mux_read_fifo_q_o);
		if (!reset_n_afi_clk)
		begin
			check_valid("afi_rdata_valid", '0, afi_rdata_valid_o);
			check_oct("force_oct_off", '0, force_oct_off_o);
		end
		else
		begin
			check_valid("afi_rdata_valid", expected_valid(n), afi_rdata_valid_o);
			check_oct("force_oct_off", expected_oct(n), force_oct_off_o);
		end
	end

	// **************************************************
	// Stimulus
	// **************************************************

	// Drives one cycle of inputs with random filler on phase 1 and on the capture data
	task automatic drive_cycle(input logic en, input logic full);
		@(negedge pll_afi_clk);
		afi_rdata_en_i      = {1'($urandom), en};
		afi_rdata_en_full_i = {1'($urandom), full};
		ddio_phy_dq_i       = {$urandom, $urandom};
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			drive_cycle(1'b0, 1'b0);
		end
	endtask

	// Counts edges until valid rises or termination drops, and compares the count
	task automatic expect_delay(input bit on_oct, input int exp_edges);
		int edges;
		bit failed;
		edges = 0;
		failed = 1'b0;
		while ((on_oct ? (force_oct_off_o != '0) : (afi_rdata_valid_o == '0))
			&& edges < WAIT_LIMIT)
		begin
			@(posedge pll_afi_clk);
			#1;
			edges++;
		end
		if (edges >= WAIT_LIMIT)
		begin
			failed = 1'b1;
			$display("Timed out after %0d cycles waiting for the DUT to respond", WAIT_LIMIT);
		end
		else if (edges != exp_edges)
		begin
			failed = 1'b1;
			$display("mismatch at %0d ns: %s delay expected %0d, got %0d", $time,
				on_oct ? "force_oct_off" : "afi_rdata_valid", exp_edges, edges);
		end
		if (failed && on_oct)
		begin
			oct_errors++;
		end
		else if (failed)
		begin
			valid_errors++;
		end
	endtask

	initial
	begin
		int edges;
		seed_draw = $urandom(89905);
		valid_errors = 0;
		data_errors = 0;
		oct_errors = 0;
		reset_n_afi_clk = 1'b0;
		// Requests held high during reset must never reach the valid output
		afi_rdata_en_i = '1;
		afi_rdata_en_full_i = '0;
		seq_read_latency_counter_i = 5'd5;
		ddio_phy_dq_i = '0;
		repeat (10) @(negedge pll_afi_clk);
		afi_rdata_en_i = '0;
		reset_n_afi_clk = 1'b1;
		idle_cycles(20);

		// A single read at L = 5 is sampled on the edge between the two drives
		drive_cycle(1'b1, 1'b0);
		drive_cycle(1'b0, 1'b0);
		expect_delay(1'b0, 6);

		// Random request streams where the latency only moves once the history is empty
		for (int i = 0; i < 3; i++)
		begin
			idle_cycles(20);
			seq_read_latency_counter_i = read_dp_pkg::lat_cnt_t'(lat_list[i]);
			repeat (200)
			begin
				drive_cycle(($urandom % 5) < 2, ($urandom % 8) == 0);
			end
		end

		// Termination pulses start with a single one so its window start can be timed
		idle_cycles(20);
		drive_cycle(1'b0, 1'b1);
		drive_cycle(1'b0, 1'b0);
		expect_delay(1'b1, OCT_ON);
		idle_cycles(15);
		repeat (4) drive_cycle(1'b0, 1'b1);
		idle_cycles(15);
		drive_cycle(1'b0, 1'b1);
		idle_cycles(2);
		drive_cycle(1'b0, 1'b1);
		idle_cycles(15);

		// The DUT should be idle again before the run ends
		edges = 0;
		while ((afi_rdata_valid_o != '0 || force_oct_off_o != '1) && edges < WAIT_LIMIT)
		begin
			@(posedge pll_afi_clk);
			#1;
			edges++;
		end
		if (edges >= WAIT_LIMIT)
		begin
			valid_errors++;
			$display("DUT did not return to idle within %0d cycles", WAIT_LIMIT);
		end
		@(negedge pll_afi_clk);
		$display("errors: valid %0d, data %0d, oct %0d", valid_errors, data_errors, oct_errors);
		if (valid_errors + data_errors + oct_errors == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== hw/afi_read_output.sv ====
module afi_read_output (
	input  logic                   pll_afi_clk,
	input  logic                   reset_n_afi_clk,
	input  read_dp_pkg::rate_vec_t read_valid_i,
	input  read_dp_pkg::afi_data_t ddio_phy_dq_i,
	output read_dp_pkg::afi_data_t afi_rdata_o,
	output read_dp_pkg::afi_data_t phy_mux_read_fifo_q_o,
	output read_dp_pkg::rate_vec_t afi_rdata_valid_o
);

	// Short names for the lane geometry
	localparam int DQ_W     = read_dp_pkg::DQ_GROUP_WIDTH;
	localparam int SLOT_W   = read_dp_pkg::MEM_DQ_WIDTH;
	localparam int GROUP_W  = read_dp_pkg::DDIO_GROUP_DATA_WIDTH;
	localparam int N_GROUPS = read_dp_pkg::MEM_READ_DQS_WIDTH;
	localparam int N_SLOTS  = read_dp_pkg::NUM_TIMESLOTS;

	// Capture data rearranged by time slot
	read_dp_pkg::afi_data_t slot_major;

	// Slot ordered data rearranged by DQS group for the sequencer
	read_dp_pkg::afi_data_t group_major;

	// **************************************************
	// Read valid
	// **************************************************

	// Last register stage before the AFI, data is already aligned to it
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_valid_o <= '0;
		end
		else
		begin
			afi_rdata_valid_o <= read_valid_i;
		end
	end

	// **************************************************
	// Data reordering
	// **************************************************

	// The capture bus comes out of the I/O FIFOs group by group, with the
	// slots of a group side by side, e.g. G1T3 G1T2 ... G0T1 G0T0.
	// The AFI wants all groups of a slot together, e.g. G1T3 G0T3 ... G1T0 G0T0
	for (genvar g = 0; g < N_GROUPS; g++)
	begin : g_group
		for (genvar t = 0; t < N_SLOTS; t++)
		begin : g_slot
			assign slot_major[t*SLOT_W + g*DQ_W +: DQ_W] =
				ddio_phy_dq_i[g*GROUP_W + t*DQ_W +: DQ_W];

			// The sequencer calibrates each group on its own, so it gets
			// the group ordered view rebuilt from the AFI word
			assign group_major[g*GROUP_W + t*DQ_W +: DQ_W] =
				slot_major[t*SLOT_W + g*DQ_W +: DQ_W];
		end
	end

	assign afi_rdata_o           = slot_major;
	assign phy_mux_read_fifo_q_o = group_major;

	// Both phases come from the same request bit, so they never disagree
	a_valid_phases_equal: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o == {read_dp_pkg::AFI_RATE_RATIO{afi_rdata_valid_o[0]}}
	);

endmodule

// ==== hw/oct_ctrl.sv ====
module oct_ctrl #(
	parameter int MEM_T_RL = 11
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic rdata_en_full_i,
	output logic force_oct_off_o
);

	// Cycles from the read enable until termination must turn on
	localparam int ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;

	// Cycles from the read enable until termination may turn off again
	localparam int OFF_DELAY = (MEM_T_RL + 6) / 2;

	// Past full read enables, bit i is the enable from i+1 edges back
	logic [OFF_DELAY-1:0] en_hist_q;

	// Current enable on bit 0 followed by the stored history
	logic [OFF_DELAY:0] en_window;

	// **************************************************
	// Enable history
	// **************************************************

	// The live enable counts as age zero, so an on delay of zero still works
	assign en_window = {en_hist_q, rdata_en_full_i};

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist_q <= '0;
		end
		else
		begin
			en_hist_q <= en_window[OFF_DELAY-1:0];
		end
	end

	// **************************************************
	// Termination window
	// **************************************************

	// Termination stays forced off except while a read burst is on the bus,
	// which is any enable aged between the on delay and the off delay
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			force_oct_off_o <= ~(|en_window[OFF_DELAY:ON_DELAY]);
		end
	end

	// An enable must release the override once it reaches the window start
	a_oct_on_at_window_start: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		rdata_en_full_i |-> ##(ON_DELAY + 1) !force_oct_off_o
	);

endmodule

// ==== hw/rdata_en_latency_shifter.sv ====
module rdata_en_latency_shifter #(
	parameter int MAX_READ_LATENCY = 16
) (
	input  logic                        pll_afi_clk,
	input  logic                        reset_n_afi_clk,
	input  logic                        rdata_en_i,
	output logic [MAX_READ_LATENCY-1:0] read_hist_o
);

	// Bit k of the history holds the read request taken k edges earlier,
	// counting the edge that loaded it as zero
	logic [MAX_READ_LATENCY-1:0] hist_q;

	// **************************************************
	// Request history
	// **************************************************

	// The controller writes one request bit per AFI cycle whether or not a
	// read is pending, so every cycle shifts and a zero means no read
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			hist_q <= '0;
		end
		else
		begin
			// The newest request enters at bit 0 and ages toward the top
			hist_q <= {hist_q[MAX_READ_LATENCY-2:0], rdata_en_i};
		end
	end

	// The whole history goes out, the selector downstream picks the tap
	assign read_hist_o = hist_q;

endmodule

// ==== hw/read_dp_pkg.sv ====
package read_dp_pkg;

	// **************************************************
	// Memory side geometry
	// **************************************************

	// DQ pins on the memory device
	localparam int MEM_DQ_WIDTH = 16;

	// Read strobes, one per byte lane
	localparam int MEM_READ_DQS_WIDTH = 2;

	// DQ pins served by each read strobe
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / MEM_READ_DQS_WIDTH;

	// **************************************************
	// AFI side geometry
	// **************************************************

	// Half rate, so every AFI clock carries two memory clock phases
	localparam int AFI_RATE_RATIO = 2;

	// Each memory clock has two data beats, so a half rate word holds four slots
	localparam int NUM_TIMESLOTS = 2 * AFI_RATE_RATIO;

	// Full AFI read data word
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// Bits that one DQS group contributes to the capture bus
	localparam int DDIO_GROUP_DATA_WIDTH = AFI_DATA_WIDTH / MEM_READ_DQS_WIDTH;

	// One termination strobe per group and per AFI phase
	localparam int AFI_DQS_WIDTH = MEM_READ_DQS_WIDTH * AFI_RATE_RATIO;

	// Width of the read latency setting written by the sequencer
	localparam int MAX_LATENCY_COUNT_WIDTH = 5;

	// **************************************************
	// Shared types
	// **************************************************

	// One AFI data word, used for both the capture bus and the AFI buses
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;

	// One bit per AFI phase, used for read enables and read valid
	typedef logic [AFI_RATE_RATIO-1:0] rate_vec_t;

	// Read latency in AFI clock cycles
	typedef logic [MAX_LATENCY_COUNT_WIDTH-1:0] lat_cnt_t;

	// One bit per AFI strobe for the termination override
	typedef logic [AFI_DQS_WIDTH-1:0] dqs_vec_t;

endpackage

// ==== hw/read_dp_top.sv ====
module read_dp_top #(
	parameter int MAX_READ_LATENCY = 16,
	parameter int MEM_T_RL         = 11
) (
	input  logic                   pll_afi_clk,
	input  logic                   reset_n_afi_clk,
	input  read_dp_pkg::rate_vec_t afi_rdata_en_i,
	input  read_dp_pkg::rate_vec_t afi_rdata_en_full_i,
	input  read_dp_pkg::lat_cnt_t  seq_read_latency_counter_i,
	input  read_dp_pkg::afi_data_t ddio_phy_dq_i,
	output read_dp_pkg::afi_data_t afi_rdata_o,
	output read_dp_pkg::afi_data_t phy_mux_read_fifo_q_o,
	output read_dp_pkg::rate_vec_t afi_rdata_valid_o,
	output read_dp_pkg::dqs_vec_t  force_oct_off_o
);

	// History of read requests, newest in bit 0
	logic [MAX_READ_LATENCY-1:0] read_hist;

	// Valid after the latency tap, one bit per AFI phase
	read_dp_pkg::rate_vec_t read_valid;

	// Single termination override shared by all strobes
	logic oct_off;

	// **************************************************
	// Read valid path
	// **************************************************

	// Both AFI phases follow request bit 0, as the controller
	// always issues half rate reads aligned to phase 0
	rdata_en_latency_shifter #(
		.MAX_READ_LATENCY (MAX_READ_LATENCY)
	) u_latency_shifter (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_i      (afi_rdata_en_i[0]),
		.read_hist_o     (read_hist)
	);

	read_valid_selector #(
		.MAX_READ_LATENCY (MAX_READ_LATENCY)
	) u_valid_selector (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.read_hist_i     (read_hist),
		.latency_i       (seq_read_latency_counter_i),
		.read_valid_o    (read_valid)
	);

	// **************************************************
	// Data and AFI outputs
	// **************************************************

	afi_read_output u_read_output (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.read_valid_i          (read_valid),
		.ddio_phy_dq_i         (ddio_phy_dq_i),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o)
	);

	// **************************************************
	// On-die termination
	// **************************************************

	oct_ctrl #(
		.MEM_T_RL (MEM_T_RL)
	) u_oct_ctrl (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_rdata_en_full_i[0]),
		.force_oct_off_o (oct_off)
	);

	// Every strobe sees the same read window, so one bit fans out to all
	assign force_oct_off_o = {read_dp_pkg::AFI_DQS_WIDTH{oct_off}};

endmodule

// ==== hw/read_valid_selector.sv ====
module read_valid_selector #(
	parameter int MAX_READ_LATENCY = 16
) (
	input  logic                        pll_afi_clk,
	input  logic                        reset_n_afi_clk,
	input  logic [MAX_READ_LATENCY-1:0] read_hist_i,
	input  read_dp_pkg::lat_cnt_t       latency_i,
	output read_dp_pkg::rate_vec_t      read_valid_o
);

	// Index width needed to address one bit of the history
	localparam int TAP_W = $clog2(MAX_READ_LATENCY);

	// Tap number, the latency setting counts from one
	logic [TAP_W-1:0] tap_sel;

	// History bit that matches the current latency
	logic tap_bit;

	// **************************************************
	// Latency tap
	// **************************************************

	// A latency of L picks the request that is L-1 edges old, and the
	// register below adds the last cycle of the L
	assign tap_sel = TAP_W'(latency_i - 1'b1);
	assign tap_bit = read_hist_i[tap_sel];

	// In the I/O FIFO configuration the valid does not depend on the group,
	// so one tap drives every AFI phase
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_valid_o <= '0;
		end
		else
		begin
			read_valid_o <= {read_dp_pkg::AFI_RATE_RATIO{tap_bit}};
		end
	end

	// The sequencer must keep its latency inside the history depth, or the
	// tap wraps and valid shows up at the wrong cycle
	a_latency_in_range: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(latency_i >= 1) && (latency_i <= MAX_READ_LATENCY)
	);

endmodule

// ==== read_dp_top.f ====
hw/read_dp_pkg.sv
hw/rdata_en_latency_shifter.sv
hw/read_valid_selector.sv
hw/oct_ctrl.sv
hw/afi_read_output.sv
hw/read_dp_top.sv
dv/read_dp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the read datapath testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module read_dp_tb -f read_dp_top.f \
	--Mdir obj_dir -o read_dp_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/read_dp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

grep -q "TEST FAIL" "$LOG"
rc=$?
if [ $rc -eq 0 ]; then
	exit 1
elif [ $rc -ne 1 ]; then
	echo "Could not read $LOG"
	exit 1
fi
exit 0
